// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP      = shift_conv_tb
FILELIST = src.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only if the testbench printed its pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// File: common/shift_conv_pkg.sv
package shift_conv_pkg;

    // how the windows of one block combine into a result
    typedef enum logic [0:0] {
        POOL_SUM = 1'b0,
        POOL_MAX = 1'b1
    } pool_mode_e;

    // input side job sequencing
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        RUN       = 2'd1,
        WAIT_DONE = 2'd2
    } job_state_e;

    // width of the channel and block counters
    localparam int CNT_WIDTH = 8;

endpackage

// File: design/conv_job_ctrl.sv
`timescale 1ns/1ns

module conv_job_ctrl import shift_conv_pkg::*; #(
    parameter int DATA_WIDTH   = 16,
    parameter int CONV_UNITS   = 8,
    parameter int KERNEL_H_MAX = 5
) (
    input  logic                                              aclk,
    input  logic                                              arst_n,
    input  logic                                              start,
    input  logic [$clog2(KERNEL_H_MAX + 1)-1:0]               kernel_h_1,
    input  logic [CNT_WIDTH-1:0]                              cin_1,
    input  logic [CNT_WIDTH-1:0]                              blocks_1,
    input  pool_mode_e                                        pool_mode,
    input  logic                                              relu_en,
    input  logic [DATA_WIDTH*(CONV_UNITS+KERNEL_H_MAX-1)-1:0] in_data,
    input  logic                                              in_valid,
    output logic                                              in_ready,
    output logic [DATA_WIDTH*(CONV_UNITS+KERNEL_H_MAX-1)-1:0] beat_data,
    output logic                                              beat_valid,
    output logic                                              beat_first,
    output logic                                              beat_last,
    input  logic                                              beat_ready,
    output logic [$clog2(KERNEL_H_MAX + 1)-1:0]               job_kh_1,
    output pool_mode_e                                        job_mode,
    output logic                                              job_relu,
    output logic                                              last_block,
    input  logic                                              job_end,
    output logic                                              done
);

    localparam int IN_ROWS  = CONV_UNITS + KERNEL_H_MAX - 1;
    localparam int KH_WIDTH = $clog2(KERNEL_H_MAX + 1);

    job_state_e           state;
    logic [CNT_WIDTH-1:0] cin_lim;
    logic [CNT_WIDTH-1:0] blocks_lim;
    logic [CNT_WIDTH-1:0] cin_cnt;
    logic [CNT_WIDTH-1:0] blk_cnt;
    logic                 beat_accept;
    logic                 final_blk;

    // input only flows while a job is running
    assign beat_data   = in_data[DATA_WIDTH*IN_ROWS-1:0];
    assign beat_valid  = in_valid && (state == RUN);
    assign in_ready    = beat_ready && (state == RUN);
    assign beat_accept = beat_valid && beat_ready;

    assign beat_first = (cin_cnt == '0);
    assign beat_last  = (cin_cnt == cin_lim);
    assign final_blk  = (blk_cnt == blocks_lim);

    assign done = (state == WAIT_DONE) && job_end;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= IDLE;
            cin_lim    <= '0;
            blocks_lim <= '0;
            cin_cnt    <= '0;
            blk_cnt    <= '0;
            job_kh_1   <= '0;
            job_mode   <= POOL_SUM;
            job_relu   <= 1'b0;
            last_block <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        job_kh_1   <= kernel_h_1;
                        cin_lim    <= cin_1;
                        blocks_lim <= blocks_1;
                        job_mode   <= pool_mode;
                        job_relu   <= relu_en;
                        cin_cnt    <= '0;
                        blk_cnt    <= '0;
                        last_block <= 1'b0;
                        state      <= RUN;
                    end
                end
                RUN: begin
                    if (beat_accept) begin
                        // rises only once the previous block has fully drained
                        if (beat_first && final_blk) begin
                            last_block <= 1'b1;
                        end
                        if (beat_last) begin
                            cin_cnt <= '0;
                            if (final_blk) begin
                                state <= WAIT_DONE;
                            end else begin
                                blk_cnt <= blk_cnt + 1'b1;
                            end
                        end else begin
                            cin_cnt <= cin_cnt + 1'b1;
                        end
                    end
                end
                WAIT_DONE: begin
                    if (job_end) begin
                        last_block <= 1'b0;
                        state      <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_start_in_idle: assert property (
        @(posedge aclk) disable iff (!arst_n) start |-> (state == IDLE)
    );

    a_kernel_h_range: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (start && state == IDLE) |-> (kernel_h_1 < KH_WIDTH'(KERNEL_H_MAX))
    );

endmodule

// File: design/shift_conv_top.sv
`timescale 1ns/1ns

module shift_conv_top import shift_conv_pkg::*; #(
    parameter int DATA_WIDTH   = 16,
    parameter int CONV_UNITS   = 8,
    parameter int KERNEL_H_MAX = 5,
    parameter int ACC_WIDTH    = 24
) (
    input  logic                                              aclk,
    input  logic                                              arst_n,
    input  logic                                              start,
    input  logic [$clog2(KERNEL_H_MAX + 1)-1:0]               kernel_h_1,
    input  logic [CNT_WIDTH-1:0]                              cin_1,
    input  logic [CNT_WIDTH-1:0]                              blocks_1,
    input  pool_mode_e                                        pool_mode,
    input  logic                                              relu_en,
    output logic                                              done,
    input  logic [DATA_WIDTH*(CONV_UNITS+KERNEL_H_MAX-1)-1:0] in_data,
    input  logic                                              in_valid,
    output logic                                              in_ready,
    output logic [ACC_WIDTH*CONV_UNITS-1:0]                   out_data,
    output logic                                              out_valid,
    input  logic                                              out_ready,
    output logic                                              out_last
);

    localparam int IN_ROWS  = CONV_UNITS + KERNEL_H_MAX - 1;
    localparam int KH_WIDTH = $clog2(KERNEL_H_MAX + 1);

    // ctrl to shift buffer
    logic [DATA_WIDTH*IN_ROWS-1:0] beat_data;
    logic                          beat_valid;
    logic                          beat_ready;
    logic                          beat_first;
    logic                          beat_last;
    logic [KH_WIDTH-1:0]           job_kh_1;

    // shift buffer to accumulator
    logic [DATA_WIDTH*CONV_UNITS-1:0] win_data;
    logic                             win_valid;
    logic                             win_ready;
    logic                             win_first;
    logic                             win_last;

    // job settings and end of job
    pool_mode_e job_mode;
    logic       job_relu;
    logic       last_block;
    logic       job_end;

    conv_job_ctrl #(
        .DATA_WIDTH   (DATA_WIDTH),
        .CONV_UNITS   (CONV_UNITS),
        .KERNEL_H_MAX (KERNEL_H_MAX)
    ) ctrl_i (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .start      (start),
        .kernel_h_1 (kernel_h_1),
        .cin_1      (cin_1),
        .blocks_1   (blocks_1),
        .pool_mode  (pool_mode),
        .relu_en    (relu_en),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .beat_data  (beat_data),
        .beat_valid (beat_valid),
        .beat_first (beat_first),
        .beat_last  (beat_last),
        .beat_ready (beat_ready),
        .job_kh_1   (job_kh_1),
        .job_mode   (job_mode),
        .job_relu   (job_relu),
        .last_block (last_block),
        .job_end    (job_end),
        .done       (done)
    );

    axis_shift_buffer #(
        .DATA_WIDTH   (DATA_WIDTH),
        .CONV_UNITS   (CONV_UNITS),
        .KERNEL_H_MAX (KERNEL_H_MAX)
    ) shift_buf_i (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .job_kh_1   (job_kh_1),
        .beat_data  (beat_data),
        .beat_valid (beat_valid),
        .beat_first (beat_first),
        .beat_last  (beat_last),
        .beat_ready (beat_ready),
        .win_data   (win_data),
        .win_valid  (win_valid),
        .win_first  (win_first),
        .win_last   (win_last),
        .win_ready  (win_ready)
    );

    window_accumulator #(
        .DATA_WIDTH (DATA_WIDTH),
        .CONV_UNITS (CONV_UNITS),
        .ACC_WIDTH  (ACC_WIDTH)
    ) acc_i (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .job_mode   (job_mode),
        .job_relu   (job_relu),
        .last_block (last_block),
        .win_data   (win_data),
        .win_valid  (win_valid),
        .win_first  (win_first),
        .win_last   (win_last),
        .win_ready  (win_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_last   (out_last),
        .out_ready  (out_ready),
        .job_end    (job_end)
    );

endmodule

// File: design/window_accumulator.sv
`timescale 1ns/1ns

module window_accumulator import shift_conv_pkg::*; #(
    parameter int DATA_WIDTH = 16,
    parameter int CONV_UNITS = 8,
    parameter int ACC_WIDTH  = 24
) (
    input  logic                           aclk,
    input  logic                           arst_n,
    input  pool_mode_e                     job_mode,
    input  logic                           job_relu,
    input  logic                           last_block,
    input  logic [DATA_WIDTH*CONV_UNITS-1:0] win_data,
    input  logic                           win_valid,
    input  logic                           win_first,
    input  logic                           win_last,
    output logic                           win_ready,
    output logic [ACC_WIDTH*CONV_UNITS-1:0] out_data,
    output logic                           out_valid,
    output logic                           out_last,
    input  logic                           out_ready,
    output logic                           job_end
);

    logic signed [ACC_WIDTH-1:0] acc      [CONV_UNITS];
    logic signed [ACC_WIDTH-1:0] win_word [CONV_UNITS];
    logic signed [ACC_WIDTH-1:0] acc_next [CONV_UNITS];
    logic                        win_xfer;
    logic                        out_xfer;

    // windows wait while a result is pending
    assign win_ready = !out_valid;
    assign win_xfer  = win_valid && win_ready;
    assign out_xfer  = out_valid && out_ready;

    always_comb begin
        for (int u = 0; u < CONV_UNITS; u++) begin
            win_word[u] = ACC_WIDTH'($signed(win_data[u*DATA_WIDTH +: DATA_WIDTH]));
            if (win_first) begin
                acc_next[u] = win_word[u];
            end else if (job_mode == POOL_SUM) begin
                acc_next[u] = acc[u] + win_word[u];
            end else begin
                acc_next[u] = (win_word[u] > acc[u]) ? win_word[u] : acc[u];
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (win_xfer) begin
            for (int u = 0; u < CONV_UNITS; u++) begin
                acc[u] <= acc_next[u];
            end
        end
        if (win_xfer && win_last) begin
            for (int u = 0; u < CONV_UNITS; u++) begin
                // relu clamps negatives
                if (job_relu && (acc_next[u] < 0)) begin
                    out_data[u*ACC_WIDTH +: ACC_WIDTH] <= '0;
                end else begin
                    out_data[u*ACC_WIDTH +: ACC_WIDTH] <= acc_next[u];
                end
            end
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            job_end   <= 1'b0;
        end else begin
            job_end <= out_xfer && out_last;
            if (win_xfer && win_last) begin
                out_valid <= 1'b1;
                out_last  <= last_block;
            end else if (out_xfer) begin
                out_valid <= 1'b0;
                out_last  <= 1'b0;
            end
        end
    end

    a_out_hold: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> out_valid
    );

endmodule

// File: shift_buffer/axis_shift_buffer.sv
`timescale 1ns/1ns

module axis_shift_buffer #(
    parameter int DATA_WIDTH   = 16,
    parameter int CONV_UNITS   = 8,
    parameter int KERNEL_H_MAX = 5
) (
    input  logic                                              aclk,
    input  logic                                              arst_n,
    input  logic [$clog2(KERNEL_H_MAX + 1)-1:0]               job_kh_1,
    input  logic [DATA_WIDTH*(CONV_UNITS+KERNEL_H_MAX-1)-1:0] beat_data,
    input  logic                                              beat_valid,
    input  logic                                              beat_first,
    input  logic                                              beat_last,
    output logic                                              beat_ready,
    output logic [DATA_WIDTH*CONV_UNITS-1:0]                  win_data,
    output logic                                              win_valid,
    output logic                                              win_first,
    output logic                                              win_last,
    input  logic                                              win_ready
);

    localparam int IN_ROWS  = CONV_UNITS + KERNEL_H_MAX - 1;
    localparam int KH_WIDTH = $clog2(KERNEL_H_MAX + 1);

    logic [DATA_WIDTH*IN_ROWS-1:0] buf_data;
    logic                          buf_full;
    logic                          buf_first;
    logic                          buf_last;
    logic [KH_WIDTH-1:0]           shift_idx;
    logic                          last_shift;
    logic                          beat_accept;
    logic                          win_xfer;

    assign last_shift  = (shift_idx == job_kh_1);
    assign win_valid   = buf_full;
    assign win_xfer    = win_valid && win_ready;

    // a new beat may land on the same edge the final window leaves
    assign beat_ready  = !buf_full || (win_ready && last_shift);
    assign beat_accept = beat_valid && beat_ready;

    assign win_first = buf_first && (shift_idx == '0);
    assign win_last  = buf_last && last_shift;

    // unit u sees row u + s of the held beat
    always_comb begin
        for (int u = 0; u < CONV_UNITS; u++) begin
            win_data[u*DATA_WIDTH +: DATA_WIDTH] =
                buf_data[(u + int'(shift_idx))*DATA_WIDTH +: DATA_WIDTH];
        end
    end

    always_ff @(posedge aclk) begin
        if (beat_accept) begin
            buf_data <= beat_data;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            buf_full  <= 1'b0;
            buf_first <= 1'b0;
            buf_last  <= 1'b0;
            shift_idx <= '0;
        end else begin
            if (beat_accept) begin
                buf_full  <= 1'b1;
                buf_first <= beat_first;
                buf_last  <= beat_last;
                shift_idx <= '0;
            end else if (win_xfer) begin
                if (last_shift) begin
                    buf_full  <= 1'b0;
                    shift_idx <= '0;
                end else begin
                    shift_idx <= shift_idx + 1'b1;
                end
            end
        end
    end

    a_win_stable: assert property (
        @(posedge aclk) disable iff (!arst_n)
        (win_valid && !win_ready) |=> $stable(win_data)
    );

endmodule

// File: src.f
common/shift_conv_pkg.sv
design/conv_job_ctrl.sv
shift_buffer/axis_shift_buffer.sv
design/window_accumulator.sv
design/shift_conv_top.sv
verif/shift_conv_tb.sv

// File: verif/shift_conv_tb.sv
`timescale 1ns/1ns

module shift_conv_tb
    import shift_conv_pkg::*;
();

    localparam int DATA_WIDTH   = 16;
    localparam int CONV_UNITS   = 8;
    localparam int KERNEL_H_MAX = 5;
    localparam int ACC_WIDTH    = 24;
    localparam int IN_ROWS      = CONV_UNITS + KERNEL_H_MAX - 1;
    localparam int KH_WIDTH     = $clog2(KERNEL_H_MAX + 1);
    localparam int DRIVE_DELAY  = 10;
    localparam int NUM_JOBS     = 10;

    // job table, one entry per job in each column
    localparam int         JOB_KH   [NUM_JOBS] = '{0, 2, 4, 2, 1, 1, 2, 4, 0, 0};
    localparam int         JOB_CIN  [NUM_JOBS] = '{2, 1, 3, 2, 0, 3, 3, 2, 3, 0};
    localparam int         JOB_BLK  [NUM_JOBS] = '{3, 2, 1, 2, 3, 2, 3, 2, 1, 4};
    localparam pool_mode_e JOB_MODE [NUM_JOBS] = '{POOL_SUM, POOL_SUM, POOL_SUM, POOL_MAX,
        POOL_MAX, POOL_SUM, POOL_SUM, POOL_MAX, POOL_MAX, POOL_SUM};
    localparam bit JOB_RELU [NUM_JOBS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
        1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
    // percent chance of an idle cycle before a beat / of out_ready low in a cycle
    localparam int JOB_GAP   [NUM_JOBS] = '{0, 0, 0, 0, 0, 0, 30, 40, 25, 0};
    localparam int JOB_STALL [NUM_JOBS] = '{0, 0, 0, 0, 0, 0, 30, 40, 25, 0};

    logic                            aclk;
    logic                            arst_n;
    logic                            start;
    logic [KH_WIDTH-1:0]             kernel_h_1;
    logic [CNT_WIDTH-1:0]            cin_1;
    logic [CNT_WIDTH-1:0]            blocks_1;
    pool_mode_e                      pool_mode;
    logic                            relu_en;
    logic                            done;
    logic [DATA_WIDTH*IN_ROWS-1:0]   in_data;
    logic                            in_valid;
    logic                            in_ready;
    logic [ACC_WIDTH*CONV_UNITS-1:0] out_data;
    logic                            out_valid;
    logic                            out_ready;
    logic                            out_last;

    logic [DATA_WIDTH*IN_ROWS-1:0]   beat_q     [$];
    logic [ACC_WIDTH*CONV_UNITS-1:0] exp_data_q [$];
    logic                            exp_last_q [$];
    int                              fail_count;

    shift_conv_top dut_i (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    initial begin : watchdog
        int limit;
        limit = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            limit += (JOB_CIN[j] + 1) * (JOB_BLK[j] + 1) * (JOB_KH[j] + 2) + 20;
        end
        repeat (limit) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    function automatic bit roll_percent(input int pct);
        return int'($urandom_range(99)) < pct;
    endfunction

    task automatic check_result(
        input logic [ACC_WIDTH*CONV_UNITS-1:0] got_data,
        input logic                            got_last,
        input logic [ACC_WIDTH*CONV_UNITS-1:0] exp_data,
        input logic                            exp_last,
        input int                              index
    );
        if (got_data !== exp_data || got_last !== exp_last) begin
            fail_count++;
            $display("[ERROR] %0t: result %0d is %h last %b, expected %h last %b",
                     $time, index, got_data, got_last, exp_data, exp_last);
            $display("Regression failed");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_count++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // random beats and the expected result of every block
    task automatic build_job(input int j);
        logic [DATA_WIDTH*IN_ROWS-1:0]   beat;
        logic [ACC_WIDTH*CONV_UNITS-1:0] res;
        int                              acc [CONV_UNITS];
        int                              val;
        int                              sample;
        beat_q.delete();
        exp_data_q.delete();
        exp_last_q.delete();
        for (int b = 0; b <= JOB_BLK[j]; b++) begin
            for (int c = 0; c <= JOB_CIN[j]; c++) begin
                for (int r = 0; r < IN_ROWS; r++) begin
                    sample = int'($urandom_range(4000)) - 2000;
                    beat[r*DATA_WIDTH +: DATA_WIDTH] = DATA_WIDTH'(sample);
                end
                beat_q.push_back(beat);
                for (int s = 0; s <= JOB_KH[j]; s++) begin
                    for (int u = 0; u < CONV_UNITS; u++) begin
                        val = int'($signed(beat[(u + s)*DATA_WIDTH +: DATA_WIDTH]));
                        if (c == 0 && s == 0) begin
                            acc[u] = val;
                        end else if (JOB_MODE[j] == POOL_SUM) begin
                            acc[u] = acc[u] + val;
                        end else if (val > acc[u]) begin
                            acc[u] = val;
                        end
                    end
                end
            end
            for (int u = 0; u < CONV_UNITS; u++) begin
                res[u*ACC_WIDTH +: ACC_WIDTH] =
                    (JOB_RELU[j] && acc[u] < 0) ? '0 : ACC_WIDTH'(acc[u]);
            end
            exp_data_q.push_back(res);
            exp_last_q.push_back(b == JOB_BLK[j]);
        end
    endtask

    task automatic start_job(input int j);
        start      = 1'b1;
        kernel_h_1 = KH_WIDTH'(JOB_KH[j]);
        cin_1      = CNT_WIDTH'(JOB_CIN[j]);
        blocks_1   = CNT_WIDTH'(JOB_BLK[j]);
        pool_mode  = JOB_MODE[j];
        relu_en    = JOB_RELU[j];
        @(posedge aclk);
        #DRIVE_DELAY;
        start = 1'b0;
    endtask

    task automatic drive_beats(input int j);
        bit taken;
        for (int i = 0; i < beat_q.size(); i++) begin
            if (roll_percent(JOB_GAP[j])) begin
                in_valid = 1'b0;
                @(posedge aclk);
                #DRIVE_DELAY;
            end
            in_data  = beat_q[i];
            in_valid = 1'b1;
            taken    = 1'b0;
            while (!taken) begin
                @(negedge aclk);
                taken = in_ready;
                @(posedge aclk);
                #DRIVE_DELAY;
            end
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_results(input int j);
        int                              n;
        bit                              held;
        logic [ACC_WIDTH*CONV_UNITS-1:0] held_data;
        logic                            held_last;
        n         = 0;
        held      = 1'b0;
        held_data = '0;
        held_last = 1'b0;
        out_ready = !roll_percent(JOB_STALL[j]);
        while (n < exp_data_q.size()) begin
            @(negedge aclk);
            check_flag("done", done, 1'b0);
            // a stalled result must not change
            if (held) begin
                check_flag("out_valid", out_valid, 1'b1);
                check_result(out_data, out_last, held_data, held_last, n);
            end
            held = 1'b0;
            if (out_valid && out_ready) begin
                check_result(out_data, out_last, exp_data_q[n], exp_last_q[n], n);
                n++;
            end else if (out_valid) begin
                held      = 1'b1;
                held_data = out_data;
                held_last = out_last;
            end
            @(posedge aclk);
            #DRIVE_DELAY;
            out_ready = !roll_percent(JOB_STALL[j]);
        end
        // one cycle after the final transfer
        @(negedge aclk);
        check_flag("done", done, 1'b1);
        @(posedge aclk);
        #DRIVE_DELAY;
    endtask

    // nothing may enter or leave outside a job
    task automatic check_idle(input int cycles);
        in_valid = 1'b1;
        repeat (cycles) begin
            @(negedge aclk);
            check_flag("in_ready", in_ready, 1'b0);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("out_last", out_last, 1'b0);
            check_flag("done", done, 1'b0);
            @(posedge aclk);
            #DRIVE_DELAY;
        end
        in_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hb2c2));
        fail_count = 0;
        arst_n     = 1'b0;
        start      = 1'b0;
        kernel_h_1 = '0;
        cin_1      = '0;
        blocks_1   = '0;
        pool_mode  = POOL_SUM;
        relu_en    = 1'b0;
        in_data    = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b0;
        repeat (3) @(posedge aclk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        check_idle(4);
        for (int j = 0; j < NUM_JOBS; j++) begin
            build_job(j);
            start_job(j);
            fork
                drive_beats(j);
                collect_results(j);
            join
            check_idle(3);
        end
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
